// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build dbus_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module dbus_tb -f list.f -Mdir obj_dir
	./obj_dir/Vdbus_tb | tee $(LOG)
	@if grep -q "^STATUS: PASS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
logic/dbus_pkg.sv
logic/dbus_wait_timer.sv
logic/dbus_req_ctrl.sv
logic/dbus_interconnect.sv
logic/dmem.sv
logic/gpio_regs.sv
logic/dbus_top.sv
test/dbus_tb.sv

// File: logic/dbus_interconnect.sv
`timescale 1ns/10ps

module dbus_interconnect #(
    parameter int DMEM_WORDS = 256
) (
    input  dbus_pkg::lsu2dbus_s  lsu2dbus_i,
    input  dbus_pkg::peri2dbus_s mem2dbus_i,
    input  dbus_pkg::peri2dbus_s gpio2dbus_i,
    output dbus_pkg::dbus2peri_s dbus2peri_o,
    output logic                 dmem_sel_o,
    output logic                 gpio_sel_o,
    output dbus_pkg::dbus2lsu_s  dbus2lsu_o,
    output logic                 rsp_ack_o
);
    import dbus_pkg::*;

    localparam dbus_addr_t DMEM_LIMIT = dbus_addr_t'(DMEM_WORDS * 4);

    dbus_addr_t addr;
    logic       bus_req;
    logic       dmem_match;
    logic       gpio_match;
    logic [1:0] byte_off;

    assign addr       = lsu2dbus_i.addr;
    assign byte_off   = addr[1:0];
    assign bus_req    = lsu2dbus_i.ld_req | lsu2dbus_i.st_req;
    assign dmem_match = (addr < DMEM_LIMIT);          // Memory sits at the bottom
    assign gpio_match = (addr[31:12] == GPIO_PAGE);

    // Priority decode, memory wins over the peripheral pages
    always_comb begin
        dmem_sel_o = 1'b0;
        gpio_sel_o = 1'b0;
        if (dmem_match && bus_req) begin
            dmem_sel_o = 1'b1;
        end else if (gpio_match && bus_req) begin
            gpio_sel_o = 1'b1;
        end
    end

    // Move store data into its byte lanes
    always_comb begin
        dbus2peri_o.addr = addr;
        dbus2peri_o.req  = bus_req;
        dbus2peri_o.w_en = lsu2dbus_i.st_req;
        case (lsu2dbus_i.st_ops)
            ST_OPS_SB: begin
                dbus2peri_o.w_data   = dbus_data_t'(lsu2dbus_i.w_data[7:0]) << {byte_off, 3'b000};
                dbus2peri_o.sel_byte = byte_sel_t'(4'b0001 << byte_off);
            end
            ST_OPS_SH: begin
                // Halfword alignment only looks at bit 1
                dbus2peri_o.w_data   = dbus_data_t'(lsu2dbus_i.w_data[15:0])
                                       << {byte_off[1], 4'b0000};
                dbus2peri_o.sel_byte = byte_off[1] ? 4'b1100 : 4'b0011;
            end
            ST_OPS_SW: begin
                dbus2peri_o.w_data   = lsu2dbus_i.w_data;
                dbus2peri_o.sel_byte = 4'b1111;
            end
            default: begin
                dbus2peri_o.w_data   = '0;
                dbus2peri_o.sel_byte = '0;
            end
        endcase
    end

    // Read data and ack back from the selected peripheral
    always_comb begin
        dbus2lsu_o.err = 1'b0;   // Timeouts flagged in the controller
        if (dmem_sel_o) begin
            dbus2lsu_o.r_data = mem2dbus_i.r_data;
            rsp_ack_o         = mem2dbus_i.ack;
        end else if (gpio_sel_o) begin
            dbus2lsu_o.r_data = gpio2dbus_i.r_data;
            rsp_ack_o         = gpio2dbus_i.ack;
        end else begin
            dbus2lsu_o.r_data = '0;
            rsp_ack_o         = 1'b0;
        end
    end

    // Memory never reaches into the GPIO page, and no peripheral acks an access it does not own
    always_comb begin
        a_map_onehot: assert ($onehot0({dmem_match, gpio_match}));
        a_ack_owned: assert (!(mem2dbus_i.ack && !dmem_sel_o)
                             && !(gpio2dbus_i.ack && !gpio_sel_o));
    end

endmodule : dbus_interconnect

// File: logic/dbus_pkg.sv
package dbus_pkg;

    // Bus widths
    typedef logic [31:0] dbus_addr_t;   // Byte address
    typedef logic [31:0] dbus_data_t;
    typedef logic [3:0]  byte_sel_t;    // One bit per byte lane
    typedef logic [1:0]  st_ops_t;

    // Store width encoding as driven by the LSU
    localparam st_ops_t ST_OPS_NONE = 2'b00;
    localparam st_ops_t ST_OPS_SB   = 2'b01;
    localparam st_ops_t ST_OPS_SH   = 2'b10;
    localparam st_ops_t ST_OPS_SW   = 2'b11;

    // Core to bus request
    typedef struct packed {
        dbus_addr_t addr;
        dbus_data_t w_data;
        st_ops_t    st_ops;
        logic       ld_req;
        logic       st_req;
    } lsu2dbus_s;

    typedef struct packed {
        dbus_addr_t addr;
        dbus_data_t w_data;
        byte_sel_t  sel_byte;
        logic       req;
        logic       w_en;
    } dbus2peri_s;

    typedef struct packed {
        dbus_data_t r_data;
        logic       ack;    // Single cycle
    } peri2dbus_s;

    // Response back to the core
    typedef struct packed {
        dbus_data_t r_data;
        logic       err;    // Set on bus timeout
    } dbus2lsu_s;

    // GPIO block and its page in the memory map
    localparam int unsigned GPIO_WIDTH      = 16;
    localparam logic [19:0] GPIO_PAGE       = 20'h80000;  // Address bits 31..12
    localparam logic [11:0] GPIO_OUT_OFFSET = 12'h000;
    localparam logic [11:0] GPIO_IN_OFFSET  = 12'h004;

endpackage : dbus_pkg

// File: logic/dbus_req_ctrl.sv
`timescale 1ns/10ps

module dbus_req_ctrl #(
    parameter int REQ_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                req_valid_i,
    input  dbus_pkg::lsu2dbus_s req_i,
    output logic                credit_o,
    output dbus_pkg::lsu2dbus_s bus_o,
    input  dbus_pkg::dbus2lsu_s bus_rsp_i,
    input  logic                bus_ack_i,
    output logic                timer_clear_o,
    input  logic                timer_expired_i,
    output logic                rsp_valid_o,
    output dbus_pkg::dbus2lsu_s rsp_o
);
    import dbus_pkg::*;

    localparam int PTR_W = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(REQ_DEPTH + 1);

    typedef enum logic [1:0] {IDLE, BUSY, RESP} state_t;

    state_t           state_q, state_d;
    lsu2dbus_s        fifo_mem [REQ_DEPTH];
    lsu2dbus_s        cur_req_q;           // Request held on the bus
    dbus2lsu_s        rsp_q;
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             fifo_empty, fifo_full;
    logic             push, pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(REQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign fifo_empty = (count_q == '0);
    assign fifo_full  = (count_q == CNT_W'(REQ_DEPTH));
    assign push       = req_valid_i && !fifo_full;
    assign pop        = (state_q == IDLE) && !fifo_empty;   // Issue straight from the head

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (pop) state_d = BUSY;
            BUSY: if (bus_ack_i || timer_expired_i) state_d = RESP;
            RESP: state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q  <= IDLE;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            state_q <= state_d;
            if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
            if (push && !pop) count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) fifo_mem[wr_ptr_q] <= req_i;
        if (pop) cur_req_q <= fifo_mem[rd_ptr_q];
        if (state_q == BUSY) begin
            if (bus_ack_i) rsp_q <= bus_rsp_i;
            else if (timer_expired_i) rsp_q <= '{r_data: '0, err: 1'b1};  // No target answered
        end
    end

    always_comb begin
        case (state_q)
            IDLE:    bus_o = fifo_empty ? '0 : fifo_mem[rd_ptr_q];
            BUSY:    bus_o = cur_req_q;
            default: bus_o = '0;
        endcase
    end

    assign credit_o      = pop;    // One credit back per dequeue
    assign timer_clear_o = (state_q != BUSY);
    assign rsp_valid_o   = (state_q == RESP);
    assign rsp_o         = rsp_q;

    // Requester must hold a credit for every push
    a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
        req_valid_i |-> !fifo_full);

endmodule : dbus_req_ctrl

// File: logic/dbus_top.sv
`timescale 1ns/10ps

module dbus_top #(
    parameter int REQ_DEPTH      = 4,
    parameter int TIMEOUT_CYCLES = 8,
    parameter int DMEM_WORDS     = 256
) (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            req_valid_i,
    input  dbus_pkg::lsu2dbus_s             req_i,
    output logic                            credit_o,
    output logic                            rsp_valid_o,
    output dbus_pkg::dbus2lsu_s             rsp_o,
    input  logic [dbus_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [dbus_pkg::GPIO_WIDTH-1:0] gpio_out_o
);
    import dbus_pkg::*;

    lsu2dbus_s  bus_req;
    dbus2lsu_s  bus_rsp;
    dbus2peri_s dbus2peri;
    peri2dbus_s mem2dbus;
    peri2dbus_s gpio2dbus;
    logic       bus_ack;
    logic       timer_clear, timer_expired;
    logic       dmem_sel, gpio_sel;

    dbus_req_ctrl #(.REQ_DEPTH(REQ_DEPTH)) u_req_ctrl (
        .clk             (clk),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_i           (req_i),
        .credit_o        (credit_o),
        .bus_o           (bus_req),
        .bus_rsp_i       (bus_rsp),
        .bus_ack_i       (bus_ack),
        .timer_clear_o   (timer_clear),
        .timer_expired_i (timer_expired),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_o           (rsp_o)
    );

    dbus_wait_timer #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) u_wait_timer (
        .clk       (clk),
        .rst_i     (rst_i),
        .clear_i   (timer_clear),
        .expired_o (timer_expired)
    );

    dbus_interconnect #(.DMEM_WORDS(DMEM_WORDS)) u_interconnect (
        .lsu2dbus_i  (bus_req),
        .mem2dbus_i  (mem2dbus),
        .gpio2dbus_i (gpio2dbus),
        .dbus2peri_o (dbus2peri),
        .dmem_sel_o  (dmem_sel),
        .gpio_sel_o  (gpio_sel),
        .dbus2lsu_o  (bus_rsp),
        .rsp_ack_o   (bus_ack)
    );

    dmem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .clk         (clk),
        .rst_i       (rst_i),
        .sel_i       (dmem_sel),
        .dbus2peri_i (dbus2peri),
        .mem2dbus_o  (mem2dbus)
    );

    gpio_regs u_gpio (
        .clk         (clk),
        .rst_i       (rst_i),
        .sel_i       (gpio_sel),
        .dbus2peri_i (dbus2peri),
        .gpio_in_i   (gpio_in_i),
        .gpio_out_o  (gpio_out_o),
        .gpio2dbus_o (gpio2dbus)
    );

endmodule : dbus_top

// File: logic/dbus_wait_timer.sv
`timescale 1ns/10ps

module dbus_wait_timer #(
    parameter int TIMEOUT_CYCLES = 8
) (
    input  logic clk,
    input  logic rst_i,
    input  logic clear_i,
    output logic expired_o
);

    localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);

    logic [CNT_W-1:0] count_q;

    // Counts only while an access is waiting, holds at the limit
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            count_q <= '0;
        end else if (!expired_o) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign expired_o = (count_q == CNT_W'(TIMEOUT_CYCLES));

endmodule : dbus_wait_timer

// File: logic/dmem.sv
`timescale 1ns/10ps

module dmem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 sel_i,
    input  dbus_pkg::dbus2peri_s dbus2peri_i,
    output dbus_pkg::peri2dbus_s mem2dbus_o
);
    import dbus_pkg::*;

    localparam int         IDX_W     = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;
    localparam dbus_addr_t MEM_BYTES = dbus_addr_t'(DMEM_WORDS * 4);

    dbus_data_t       mem [DMEM_WORDS];
    dbus_data_t       r_data_q;
    logic             ack_q;
    logic             access;
    logic [IDX_W-1:0] word_idx;

    assign word_idx = dbus2peri_i.addr[IDX_W+1:2];
    // The ack flag blocks a second access while the request is still held
    assign access   = sel_i && dbus2peri_i.req && !ack_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && dbus2peri_i.w_en) begin
            for (int b = 0; b < 4; b++) begin
                if (dbus2peri_i.sel_byte[b]) mem[word_idx][b*8 +: 8] <= dbus2peri_i.w_data[b*8 +: 8];
            end
        end
        if (access) r_data_q <= dbus2peri_i.w_en ? '0 : mem[word_idx];  // Stores read back zero
    end

    assign mem2dbus_o = '{r_data: r_data_q, ack: ack_q};

    // Decoder never routes an address past the top of the array here
    a_addr_in_range: assert property (@(posedge clk) disable iff (rst_i)
        sel_i |-> (dbus2peri_i.addr < MEM_BYTES));

endmodule : dmem

// File: logic/gpio_regs.sv
`timescale 1ns/10ps

module gpio_regs (
    input  logic                            clk,
    input  logic                            rst_i,
    input  logic                            sel_i,
    input  dbus_pkg::dbus2peri_s            dbus2peri_i,
    input  logic [dbus_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [dbus_pkg::GPIO_WIDTH-1:0] gpio_out_o,
    output dbus_pkg::peri2dbus_s            gpio2dbus_o
);
    import dbus_pkg::*;

    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] in_q;
    logic [11:0]           offset;    // Within the page
    logic                  ack_q;
    logic                  access;
    dbus_data_t            out_word, merged, rd_word, r_data_q;

    assign offset   = dbus2peri_i.addr[11:0];
    assign access   = sel_i && dbus2peri_i.req && !ack_q;
    assign out_word = dbus_data_t'(out_q);

    always_comb begin
        merged = out_word;
        for (int b = 0; b < 4; b++) begin
            if (dbus2peri_i.sel_byte[b]) merged[b*8 +: 8] = dbus2peri_i.w_data[b*8 +: 8];
        end
    end

    always_comb begin
        case (offset)
            GPIO_OUT_OFFSET: rd_word = out_word;
            GPIO_IN_OFFSET:  rd_word = dbus_data_t'(in_q);
            default:         rd_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_q <= '0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
            // Input register ignores writes
            if (access && dbus2peri_i.w_en && (offset == GPIO_OUT_OFFSET)) begin
                out_q <= merged[GPIO_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        in_q <= gpio_in_i;    // Pins sampled every cycle
        if (access) r_data_q <= dbus2peri_i.w_en ? '0 : rd_word;
    end

    assign gpio_out_o  = out_q;
    assign gpio2dbus_o = '{r_data: r_data_q, ack: ack_q};

endmodule : gpio_regs

// File: test/dbus_tb.sv
`timescale 1ns/10ps

module dbus_tb;
    import dbus_pkg::*;

    localparam int REQ_DEPTH  = 4;
    localparam int DMEM_WORDS = 256;
    localparam int WAIT_LIMIT = 2000;    // Cycles allowed per wait loop

    typedef struct packed {
        dbus_data_t            r_data;
        logic                  err;
        logic                  chk_data;   // Loads and bus errors only
        logic                  chk_gpio;
        logic [GPIO_WIDTH-1:0] gpio;
    } exp_t;

    logic                  clk = 1'b0;
    logic                  rst_i;
    logic                  req_valid_i;
    lsu2dbus_s             req_i;
    logic                  credit_o;
    logic                  rsp_valid_o;
    dbus2lsu_s             rsp_o;
    logic [GPIO_WIDTH-1:0] gpio_in_i;
    logic [GPIO_WIDTH-1:0] gpio_out_o;

    logic [7:0]            mem_model [DMEM_WORDS*4];    // Byte view of the data memory
    logic [GPIO_WIDTH-1:0] gpio_model;
    exp_t                  exp_q [$];
    exp_t                  rsp_exp;
    int                    rd_idx = 0;                  // Next expected response
    int                    sent = 0;
    int                    credits_back = 0;
    int                    received = 0;
    int                    errors = 0;
    int                    mon_errors = 0;
    int                    err_start;
    logic                  hung = 1'b0;
    dbus_addr_t            a;
    int unsigned           pick;

    dbus_top u_dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .credit_o    (credit_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .gpio_in_i   (gpio_in_i),
        .gpio_out_o  (gpio_out_o)
    );

    always #2 clk = ~clk;

    function automatic bit value_ok(input string name, input logic [31:0] got,
                                    input logic [31:0] exp);
        bit ok;
        ok = (got === exp);
        assert (ok) else $display("ERROR at %0d ns: %s = 0x%08h, expected 0x%08h",
                                  $time, name, got, exp);
        return ok;
    endfunction

    function automatic int credits();
        return REQ_DEPTH - sent + credits_back;
    endfunction

    function automatic dbus_addr_t word_addr();
        return dbus_addr_t'($urandom_range(0, DMEM_WORDS - 1) * 4);
    endfunction

    // Lane rule: SB at addr[1:0], SH at the half picked by addr[1], SW on the whole word
    task automatic model_access(input dbus_addr_t addr, input dbus_data_t data,
                                input st_ops_t ops, input logic store, output exp_t e);
        int          lane;
        int          nbytes;
        int unsigned base;
        dbus_data_t  w;
        lane   = (ops == ST_OPS_SB) ? int'(addr[1:0]) : (ops == ST_OPS_SH) ? 2 * int'(addr[1]) : 0;
        nbytes = (ops == ST_OPS_SB) ? 1 : (ops == ST_OPS_SH) ? 2 : 4;
        base   = {addr[31:2], 2'b00};
        e          = '0;
        e.chk_data = !store;
        if (addr < DMEM_WORDS * 4) begin
            for (int i = 0; i < nbytes && store; i++) begin
                mem_model[base + lane + i] = data[8*i +: 8];
            end
            e.r_data = {mem_model[base+3], mem_model[base+2], mem_model[base+1], mem_model[base]};
        end else if (addr[31:12] == GPIO_PAGE) begin
            if (store && addr[11:0] == GPIO_OUT_OFFSET) begin
                w = dbus_data_t'(gpio_model);
                for (int i = 0; i < nbytes; i++) begin
                    w[8*(lane+i) +: 8] = data[8*i +: 8];
                end
                gpio_model = w[GPIO_WIDTH-1:0];
            end
            e.chk_gpio = store;
            e.gpio     = gpio_model;
            if (addr[11:0] == GPIO_OUT_OFFSET) e.r_data = dbus_data_t'(gpio_model);
            else if (addr[11:0] == GPIO_IN_OFFSET) e.r_data = dbus_data_t'(gpio_in_i);
        end else begin
            e.err      = 1'b1;    // Unmapped, data stays zero
            e.chk_data = 1'b1;
        end
    endtask

    task automatic send_req(input dbus_addr_t addr, input dbus_data_t data,
                            input st_ops_t ops, input logic store);
        exp_t e;
        int   waited;
        if (hung) return;
        waited = 0;
        while (credits() == 0 && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (credits() > 0) else begin
            $display("Timed out at %0d ns waiting for a credit", $time);
            hung = 1'b1;
        end
        if (credits() > 0) begin
            model_access(addr, data, ops, store, e);
            exp_q.push_back(e);
            req_i = '{addr: addr, w_data: data, st_ops: store ? ops : ST_OPS_NONE,
                      ld_req: !store, st_req: store};
            req_valid_i = 1'b1;
            sent++;
            @(negedge clk);
            req_valid_i = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        if (hung) return;
        waited = 0;
        while ((rd_idx != exp_q.size() || credits() != REQ_DEPTH) && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        assert (rd_idx == exp_q.size() && credits() == REQ_DEPTH) else begin
            $display("Timed out at %0d ns with %0d responses missing",
                     $time, exp_q.size() - rd_idx);
            hung = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int start);
        drain();
        $display("test %-8s %s, %0d errors", name,
                 (errors + mon_errors == start && !hung) ? "ok" : "failed",
                 errors + mon_errors - start);
    endtask

    // Credits and responses sampled at the edge the DUT registers on
    always @(posedge clk) begin
        if (!rst_i) begin
            if (credit_o) begin
                credits_back++;
                assert (credits_back <= sent) else begin
                    $display("Credit returned at %0d ns beyond the requests sent", $time);
                    mon_errors++;
                end
            end
            if (rsp_valid_o) begin
                received++;
                assert (rd_idx < exp_q.size()) else begin
                    $display("Response at %0d ns with no request outstanding", $time);
                    mon_errors++;
                end
                if (rd_idx < exp_q.size()) begin
                    rsp_exp = exp_q[rd_idx];
                    rd_idx++;
                    if (!value_ok("rsp_o.err", 32'(rsp_o.err), 32'(rsp_exp.err))) mon_errors++;
                    if (rsp_exp.chk_data && !value_ok("rsp_o.r_data", rsp_o.r_data, rsp_exp.r_data))
                        mon_errors++;
                    if (rsp_exp.chk_gpio
                        && !value_ok("gpio_out_o", 32'(gpio_out_o), 32'(rsp_exp.gpio)))
                        mon_errors++;
                end
            end
        end
    end

    initial begin
        void'($urandom(31));
        rst_i       = 1'b1;
        req_valid_i = 1'b0;
        req_i       = '0;
        gpio_in_i   = '0;
        gpio_model  = '0;

        err_start = 0;
        for (int c = 0; c < 13; c++) begin
            @(negedge clk);
            if (!value_ok("credit_o", 32'(credit_o), '0)) errors++;
            if (!value_ok("rsp_valid_o", 32'(rsp_valid_o), '0)) errors++;
            if (!value_ok("gpio_out_o", 32'(gpio_out_o), '0)) errors++;
            if (c == 9) rst_i = 1'b0;    // Ten rising edges in reset
        end
        report_test("reset", err_start);

        // Fill every word first so loads never see unwritten memory
        err_start = errors + mon_errors;
        for (int w = 0; w < DMEM_WORDS; w++) begin
            a = dbus_addr_t'(w * 4);
            send_req(a, (a * 32'h9e37_79b1) ^ 32'h5a0f_3c96, ST_OPS_SW, 1'b1);
        end
        repeat (60) send_req(word_addr(), $urandom, ST_OPS_SW, $urandom_range(0, 1) == 1);
        report_test("word", err_start);

        err_start = errors + mon_errors;
        repeat (40) begin
            pick = $urandom_range(0, 2);
            a    = dbus_addr_t'($urandom_range(0, DMEM_WORDS * 4 - 1));
            if (pick == 1) a[0] = 1'b0;
            if (pick == 2) a[1:0] = 2'b00;
            send_req(a, $urandom,
                     (pick == 0) ? ST_OPS_SB : (pick == 1) ? ST_OPS_SH : ST_OPS_SW, 1'b1);
            send_req({a[31:2], 2'b00}, '0, ST_OPS_NONE, 1'b0);    // Merged word back
        end
        report_test("lanes", err_start);

        err_start = errors + mon_errors;
        repeat (3) begin
            gpio_in_i = GPIO_WIDTH'($urandom);    // Steady until the loop drains
            send_req({GPIO_PAGE, GPIO_OUT_OFFSET}, $urandom, ST_OPS_SW, 1'b1);
            send_req({GPIO_PAGE, GPIO_OUT_OFFSET}, '0, ST_OPS_NONE, 1'b0);
            send_req({GPIO_PAGE, GPIO_OUT_OFFSET}, $urandom, ST_OPS_SB, 1'b1);
            send_req({GPIO_PAGE, GPIO_OUT_OFFSET}, $urandom, ST_OPS_SH, 1'b1);
            send_req({GPIO_PAGE, GPIO_OUT_OFFSET}, '0, ST_OPS_NONE, 1'b0);
            send_req({GPIO_PAGE, GPIO_IN_OFFSET}, '0, ST_OPS_NONE, 1'b0);
            send_req({GPIO_PAGE, GPIO_IN_OFFSET}, $urandom, ST_OPS_SW, 1'b1);
            send_req({GPIO_PAGE, GPIO_IN_OFFSET}, '0, ST_OPS_NONE, 1'b0);
            send_req({GPIO_PAGE, 12'h008}, '0, ST_OPS_NONE, 1'b0);    // Unused offset
            drain();
            if (!value_ok("gpio_out_o", 32'(gpio_out_o), 32'(gpio_model))) errors++;
        end
        report_test("gpio", err_start);

        err_start = errors + mon_errors;
        repeat (12) begin
            pick = $urandom_range(0, 1);
            if (pick == 0) a = 32'h4000_0000 | ($urandom & 32'h3fff_ffff);
            else a = dbus_addr_t'(DMEM_WORDS * 4) + ($urandom & 32'h0000_03fc);    // Gap above memory
            send_req(a, $urandom, ST_OPS_SW, $urandom_range(0, 1) == 1);
            send_req(word_addr(), $urandom, ST_OPS_SW, $urandom_range(0, 1) == 1);
        end
        report_test("unmapped", err_start);

        // Twice the depth, so the second half waits on returned credits
        err_start = errors + mon_errors;
        repeat (8) begin
            drain();
            repeat (2 * REQ_DEPTH) begin
                send_req(word_addr(), $urandom, ST_OPS_SW, $urandom_range(0, 1) == 1);
            end
        end
        report_test("burst", err_start);

        drain();
        assert (sent == received) else begin
            $display("Sent %0d requests but received %0d responses", sent, received);
            errors++;
        end
        $display("Summary: %0d requests, %0d responses, %0d errors%s", sent, received,
                 errors + mon_errors, hung ? ", stopped on a timeout" : "");
        if (errors + mon_errors == 0 && !hung) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule : dbus_tb
